/* wormhole_settings.svh */
// Wormhole link settings.
// Widths of the flit and packet fields and the depth of the flit buffer.
`ifndef WORMHOLE_SETTINGS_SVH
`define WORMHOLE_SETTINGS_SVH

// flit word width on the link.
`define WH_FLIT_WIDTH 16

// destination coordinate, carried through unchanged.
`define WH_CORD_WIDTH 4

// body flit count after the head, legal values are 0 to 2.
`define WH_LEN_WIDTH 3

// payload width so that a full packet is exactly three flits.
`define WH_MAX_PAYLOAD_WIDTH 41

// flits in a packet of full length.
`define WH_MAX_FLITS 3

// flits held by the link buffer.
`define WH_FIFO_DEPTH 4

`endif

/* wormhole_pkg.sv */
// Wormhole link types.
// Packet layout, link word and the two views of a flit.
`include "wormhole_settings.svh"

package wormhole_pkg;

  typedef logic [`WH_CORD_WIDTH-1:0] cord_t;
  typedef logic [`WH_LEN_WIDTH-1:0]  len_t;

  // payload bits that ride along in the head flit.
  localparam int unsigned head_payload_width_lp =
    `WH_FLIT_WIDTH - `WH_CORD_WIDTH - `WH_LEN_WIDTH;

  // A whole packet with the coordinate in the low bits.
  typedef struct packed {
    logic [`WH_MAX_PAYLOAD_WIDTH-1:0] payload;
    len_t                             len;
    cord_t                            cord;
  } packet_s;

  // Head flit fields, the low slice of a packet.
  typedef struct packed {
    logic [head_payload_width_lp-1:0] payload;
    len_t                             len;
    cord_t                            cord;
  } head_s;

  // One flit word, read as a head or as plain data.
  typedef union packed {
    head_s                     head;
    logic [`WH_FLIT_WIDTH-1:0] raw;
  } flit_u;

  // Forward half of a link, ready runs the other way.
  typedef struct packed {
    logic  v;
    flit_u data;
  } link_s;

endpackage

/* wormhole_adapter_in.sv */
// Wormhole input adapter.
// Takes one packet, cuts it into flits and sends len plus one of them.
`timescale 1ns/1ns
`include "wormhole_settings.svh"

module wormhole_adapter_in (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  wormhole_pkg::packet_s packet_i,
  input  logic                  v_i,
  output logic                  ready_o,
  output wormhole_pkg::link_s   link_o,
  input  logic                  link_ready_i
);

  localparam int unsigned buf_width_lp = `WH_MAX_FLITS * `WH_FLIT_WIDTH;
  localparam wormhole_pkg::len_t max_len_lp =
    wormhole_pkg::len_t'(`WH_MAX_FLITS - 1);

  logic [buf_width_lp-1:0] shift_r;
  wormhole_pkg::len_t      cnt_r;
  wormhole_pkg::len_t      load_len;
  logic                    busy_r;
  logic                    accept;
  logic                    send;

  assign ready_o = ~busy_r; // only idle when no flit is pending.
  assign accept  = v_i & ready_o;
  assign send    = busy_r & link_ready_i;

  // An oversized length would run past the packet, so it is capped.
  assign load_len = (packet_i.len > max_len_lp) ? max_len_lp : packet_i.len;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_r <= 1'b0;
      cnt_r  <= '0;
    end else if (accept) begin
      busy_r <= 1'b1;
      cnt_r  <= load_len; // body flits still to go after the head.
    end else if (send) begin
      if (cnt_r == '0) begin
        busy_r <= 1'b0; // last flit has left.
      end else begin
        cnt_r <= cnt_r - wormhole_pkg::len_t'(1);
      end
    end
  end

  // The packet is zero padded up to a whole number of flits.
  always_ff @(posedge clk_i) begin
    if (accept) begin
      shift_r <= buf_width_lp'(packet_i);
    end else if (send) begin
      shift_r <= shift_r >> `WH_FLIT_WIDTH;
    end
  end

  assign link_o.v        = busy_r;
  assign link_o.data.raw = shift_r[`WH_FLIT_WIDTH-1:0]; // low flit goes first.

endmodule

/* wormhole_flit_fifo.sv */
// Wormhole flit buffer.
// Circular buffer with valid/ready on both sides, read and write in one cycle.
`timescale 1ns/1ns
`include "wormhole_settings.svh"

module wormhole_flit_fifo #(
  parameter int unsigned depth_p = `WH_FIFO_DEPTH
) (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  wormhole_pkg::link_s link_i,
  output logic                ready_o,
  output wormhole_pkg::link_s link_o,
  input  logic                ready_i
);

  localparam int unsigned ptr_w_lp = $clog2(depth_p);
  localparam int unsigned cnt_w_lp = $clog2(depth_p + 1);

  wormhole_pkg::flit_u mem_r [depth_p];
  logic [ptr_w_lp-1:0] wr_ptr_r;
  logic [ptr_w_lp-1:0] rd_ptr_r;
  logic [cnt_w_lp-1:0] count_r;
  logic                wr;
  logic                rd;

  // Pointers wrap at depth_p, which need not be a power of two.
  function automatic logic [ptr_w_lp-1:0] next_ptr(input logic [ptr_w_lp-1:0] ptr);
    if (ptr == ptr_w_lp'(depth_p - 1)) begin
      return '0;
    end
    return ptr + ptr_w_lp'(1);
  endfunction

  assign ready_o = (count_r != cnt_w_lp'(depth_p)); // low only when full.
  assign wr      = link_i.v & ready_o;
  assign rd      = link_o.v & ready_i;

  assign link_o.v    = (count_r != '0);
  assign link_o.data = mem_r[rd_ptr_r];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (wr) begin
        wr_ptr_r <= next_ptr(wr_ptr_r);
      end
      if (rd) begin
        rd_ptr_r <= next_ptr(rd_ptr_r);
      end
      case ({wr, rd})
        2'b10:   count_r <= count_r + cnt_w_lp'(1);
        2'b01:   count_r <= count_r - cnt_w_lp'(1);
        default: count_r <= count_r; // both or neither leave the fill level alone.
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr) begin
      mem_r[wr_ptr_r] <= link_i.data;
    end
  end

endmodule

/* wormhole_adapter_out.sv */
// Wormhole output adapter.
// Rebuilds packets from flits using the length in the head flit.
`timescale 1ns/1ns
`include "wormhole_settings.svh"

module wormhole_adapter_out (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  wormhole_pkg::link_s   link_i,
  output logic                  link_ready_o,
  output wormhole_pkg::packet_s packet_o,
  output logic                  v_o,
  input  logic                  ready_i
);

  localparam int unsigned buf_width_lp = `WH_MAX_FLITS * `WH_FLIT_WIDTH;
  localparam int unsigned pkt_width_lp = $bits(wormhole_pkg::packet_s);
  localparam int unsigned idx_w_lp     = $clog2(`WH_MAX_FLITS);
  localparam wormhole_pkg::len_t max_len_lp =
    wormhole_pkg::len_t'(`WH_MAX_FLITS - 1);

  logic [buf_width_lp-1:0] asm_r;
  logic [idx_w_lp-1:0]     idx_r;
  wormhole_pkg::len_t      cnt_r;
  wormhole_pkg::len_t      head_len;
  logic                    body_r;
  logic                    v_r;
  logic                    take;

  assign link_ready_o = ~v_r; // no flits while a packet waits downstream.
  assign take         = link_i.v & link_ready_o;

  assign head_len = (link_i.data.head.len > max_len_lp) ? max_len_lp
                                                        : link_i.data.head.len;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      v_r    <= 1'b0;
      body_r <= 1'b0;
      cnt_r  <= '0;
      idx_r  <= '0;
    end else begin
      if (v_r && ready_i) begin
        v_r <= 1'b0;
      end
      if (take) begin
        if (!body_r) begin
          idx_r <= idx_w_lp'(1);
          cnt_r <= head_len;
          if (head_len == '0) begin
            v_r <= 1'b1; // head only packet is done at once.
          end else begin
            body_r <= 1'b1;
          end
        end else begin
          idx_r <= idx_r + idx_w_lp'(1);
          cnt_r <= cnt_r - wormhole_pkg::len_t'(1);
          if (cnt_r == wormhole_pkg::len_t'(1)) begin
            body_r <= 1'b0;
            v_r    <= 1'b1;
          end
        end
      end
    end
  end

  // Zero extension of the head flit clears every slot that is not sent.
  always_ff @(posedge clk_i) begin
    if (take) begin
      if (!body_r) begin
        asm_r <= buf_width_lp'(link_i.data.raw);
      end else begin
        asm_r[idx_r*`WH_FLIT_WIDTH +: `WH_FLIT_WIDTH] <= link_i.data.raw;
      end
    end
  end

  assign v_o      = v_r;
  assign packet_o = wormhole_pkg::packet_s'(asm_r[pkt_width_lp-1:0]);

endmodule

/* wormhole_link_top.sv */
// Wormhole link top level.
// Input adapter, flit buffer and output adapter in a row.
`timescale 1ns/1ns
`include "wormhole_settings.svh"

module wormhole_link_top (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  wormhole_pkg::packet_s packet_i,
  input  logic                  v_i,
  output logic                  ready_o,
  output wormhole_pkg::packet_s packet_o,
  output logic                  v_o,
  input  logic                  ready_i
);

  wormhole_pkg::link_s in_link;
  wormhole_pkg::link_s out_link;
  logic                in_link_ready;
  logic                out_link_ready;

  wormhole_adapter_in adapter_in (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .packet_i     (packet_i),
    .v_i          (v_i),
    .ready_o      (ready_o),
    .link_o       (in_link),
    .link_ready_i (in_link_ready)
  );

  wormhole_flit_fifo #(
    .depth_p (`WH_FIFO_DEPTH)
  ) flit_fifo (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .link_i   (in_link),
    .ready_o  (in_link_ready),
    .link_o   (out_link),
    .ready_i  (out_link_ready)
  );

  wormhole_adapter_out adapter_out (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .link_i       (out_link),
    .link_ready_o (out_link_ready),
    .packet_o     (packet_o),
    .v_o          (v_o),
    .ready_i      (ready_i)
  );

endmodule

/* wormhole_link_chk.sv */
// Wormhole link handshake checker.
// Bound into the link top level, watches the output and the producer link.
`timescale 1ns/1ns
`include "wormhole_settings.svh"

module wormhole_link_chk (
  input logic                  clk_i,
  input logic                  arst_n_i,
  input wormhole_pkg::packet_s in_packet_i,
  input logic                  in_v_i,
  input logic                  in_ready_i,
  input wormhole_pkg::packet_s out_packet_i,
  input logic                  out_v_i,
  input logic                  out_ready_i,
  input wormhole_pkg::link_s   link_i,
  input logic                  link_ready_i
);

  int out_fail_count  = 0;
  int link_fail_count = 0;
  int len_fail_count  = 0;

  // a waiting output packet must not move.
  out_stable_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (out_v_i && !out_ready_i) |=> (out_v_i && $stable(out_packet_i)))
    else begin
      out_fail_count = out_fail_count + 1;
      $error("v_o dropped or packet_o changed while the packet waited");
    end

  link_hold_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (link_i.v && !link_ready_i) |=> (link_i.v && $stable(link_i.data)))
    else begin
      link_fail_count = link_fail_count + 1;
      $error("producer link valid or flit changed before the transfer");
    end

  len_legal_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (in_v_i && in_ready_i) |-> (in_packet_i.len <= wormhole_pkg::len_t'(`WH_MAX_FLITS - 1)))
    else begin
      len_fail_count = len_fail_count + 1;
      $error("accepted packet has a length above the largest legal value");
    end

endmodule

bind wormhole_link_top wormhole_link_chk link_chk (
  .clk_i        (clk_i),
  .arst_n_i     (arst_n_i),
  .in_packet_i  (packet_i),
  .in_v_i       (v_i),
  .in_ready_i   (ready_o),
  .out_packet_i (packet_o),
  .out_v_i      (v_o),
  .out_ready_i  (ready_i),
  .link_i       (in_link),
  .link_ready_i (in_link_ready)
);

/* wormhole_link_tb.sv */
// Wormhole link testbench.
// Applies a packet table to the link, stalls the output at random in some
// entries and checks every packet that comes out, in order.
`timescale 1ns/1ns
`include "wormhole_settings.svh"

module wormhole_link_tb;

  localparam int num_entries_lp     = 12;
  localparam int pkt_width_lp       = $bits(wormhole_pkg::packet_s);
  localparam int watchdog_cycles_lp = num_entries_lp * 40;

  typedef struct packed {
    logic                  stall;
    wormhole_pkg::packet_s pkt;
    wormhole_pkg::packet_s exp;
  } entry_s;

  typedef struct packed {
    logic                  stall;
    wormhole_pkg::packet_s exp;
  } pending_s;

  logic                  clk;
  logic                  arst_n;
  wormhole_pkg::packet_s in_packet;
  logic                  in_v;
  logic                  in_ready;
  wormhole_pkg::packet_s out_packet;
  logic                  out_v;
  logic                  out_ready;

  entry_s   table_r [num_entries_lp];
  pending_s exp_q [$];
  integer   seed = 44;
  int       received = 0;

  wormhole_link_top DUT (
    .clk_i    (clk),
    .arst_n_i (arst_n),
    .packet_i (in_packet),
    .v_i      (in_v),
    .ready_o  (in_ready),
    .packet_o (out_packet),
    .v_o      (out_v),
    .ready_i  (out_ready)
  );

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  // Flits beyond len plus one never cross the link, so their bits read as zero.
  function automatic wormhole_pkg::packet_s expected_packet(input wormhole_pkg::packet_s pkt);
    logic [pkt_width_lp-1:0] bits;
    int                      sent_bits;
    bits      = pkt;
    sent_bits = (int'(pkt.len) + 1) * `WH_FLIT_WIDTH;
    for (int b = 0; b < pkt_width_lp; b++) begin
      if (b >= sent_bits) begin
        bits[b] = 1'b0;
      end
    end
    return wormhole_pkg::packet_s'(bits);
  endfunction

  function automatic entry_s make_entry(
    input logic [`WH_MAX_PAYLOAD_WIDTH-1:0] payload,
    input wormhole_pkg::len_t               len,
    input wormhole_pkg::cord_t              cord,
    input logic                             stall
  );
    entry_s e;
    e.stall       = stall;
    e.pkt.payload = payload;
    e.pkt.len     = len;
    e.pkt.cord    = cord;
    e.exp         = expected_packet(e.pkt);
    return e;
  endfunction

  task automatic fill_table();
    table_r[0]  = make_entry({1'b1, 40'hAB_CDEF_0123}, 3'd0, 4'h5, 1'b0); // head only.
    table_r[1]  = make_entry({1'b1, 40'hFF_FFFF_FFFF}, 3'd2, 4'hA, 1'b0);
    table_r[2]  = make_entry({1'b0, 40'h12_3456_789A}, 3'd2, 4'h3, 1'b0);
    table_r[3]  = make_entry({1'b1, 40'h5A_5A5A_5A5A}, 3'd2, 4'hC, 1'b0);
    table_r[4]  = make_entry({1'b1, 40'hFF_FFFF_FFFF}, 3'd1, 4'h1, 1'b1);
    table_r[5]  = make_entry({1'b0, 40'hDE_ADBE_EF01}, 3'd0, 4'h7, 1'b1);
    table_r[6]  = make_entry({1'b1, 40'h0F_0F0F_0F0F}, 3'd2, 4'hE, 1'b1);
    table_r[7]  = make_entry({1'b0, 40'h33_CC33_CC33}, 3'd1, 4'h2, 1'b1);
    table_r[8]  = make_entry({1'b1, 40'h87_6543_210F}, 3'd2, 4'h9, 1'b1);
    table_r[9]  = make_entry({1'b0, 40'hC3_C3C3_C3C3}, 3'd1, 4'h4, 1'b0);
    table_r[10] = make_entry({1'b1, 40'h11_2233_4455}, 3'd0, 4'hF, 1'b0);
    table_r[11] = make_entry({1'b0, 40'h66_7788_99AA}, 3'd2, 4'h0, 1'b0);
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    assert (got === exp) else begin
      stop_with_failure($sformatf("FAILED at %0t ns: %s is %b, expected %b",
                                  $time, name, got, exp));
    end
  endtask

  task automatic check_packet(input string name, input wormhole_pkg::packet_s got,
                              input wormhole_pkg::packet_s exp);
    assert (got === exp) else begin
      stop_with_failure($sformatf("FAILED at %0t ns: %s is %h, expected %h",
                                  $time, name, got, exp));
    end
  endtask

  // Returns at the falling edge where ready_o is high, counting the busy ones before it.
  task automatic wait_for_ready(output int low_cycles);
    low_cycles = 0;
    @(negedge clk);
    while (!in_ready) begin
      low_cycles++;
      @(negedge clk);
    end
  endtask

  task automatic check_busy_time(input int low_cycles, input int len);
    assert (low_cycles >= len + 1) else begin
      stop_with_failure($sformatf(
        "FAILED at %0t ns: ready_o low cycles is %0d, expected at least %0d",
        $time, low_cycles, len + 1));
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    int       low_cycles;
    int       prev_len;
    pending_s pend;
    fill_table();
    arst_n    = 1'b0;
    in_v      = 1'b0;
    in_packet = '0;
    repeat (4) @(posedge clk);
    #2;
    arst_n = 1'b1;
    @(negedge clk);
    check_bit("ready_o", in_ready, 1'b1);
    check_bit("v_o", out_v, 1'b0);
    @(posedge clk);
    #2;
    prev_len = -1;
    for (int i = 0; i < num_entries_lp; i++) begin
      in_packet = table_r[i].pkt;
      in_v      = 1'b1; // held until the producer takes it.
      wait_for_ready(low_cycles);
      if (prev_len >= 0) begin
        check_busy_time(low_cycles, prev_len);
      end
      pend.stall = table_r[i].stall;
      pend.exp   = table_r[i].exp;
      exp_q.push_back(pend); // accepted on the coming edge.
      @(posedge clk);
      #2;
      prev_len = int'(table_r[i].pkt.len);
    end
    in_v      = 1'b0;
    in_packet = '0;
    wait_for_ready(low_cycles);
    check_busy_time(low_cycles, prev_len);
    while (received < num_entries_lp) begin
      @(negedge clk);
    end
    repeat (4) @(negedge clk);
    if (!out_v) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      stop_with_failure("the link produced more packets than it was given");
    end
  end

  // The output ready is random only while a stalled entry is next in line.
  initial begin
    logic [31:0] r;
    out_ready = 1'b0;
    forever begin
      @(posedge clk);
      #2;
      r = $random(seed);
      if (exp_q.size() > 0 && exp_q[0].stall) begin
        out_ready = r[0];
      end else begin
        out_ready = 1'b1;
      end
    end
  end

  initial begin
    pending_s front;
    forever begin
      @(negedge clk);
      if (arst_n && out_v && out_ready) begin
        assert (exp_q.size() > 0) else begin
          stop_with_failure("a packet came out of the link while none was pending");
        end
        front = exp_q.pop_front();
        check_packet("packet_o", out_packet, front.exp);
        received++;
      end
    end
  end

  initial begin
    forever begin
      @(negedge clk);
      assert (DUT.link_chk.out_fail_count + DUT.link_chk.link_fail_count
              + DUT.link_chk.len_fail_count == 0) else begin
        stop_with_failure("a handshake assertion in the bound checker fired");
      end
    end
  end

  initial begin
    repeat (watchdog_cycles_lp) @(posedge clk);
    stop_with_failure("the watchdog ran out before every packet came out of the link");
  end

endmodule

/* verilog.f */
+incdir+.
wormhole_pkg.sv
wormhole_adapter_in.sv
wormhole_flit_fifo.sv
wormhole_adapter_out.sv
wormhole_link_top.sv
wormhole_link_chk.sv
wormhole_link_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the wormhole link testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timescale 1ns/1ns -f verilog.f \
  --top-module wormhole_link_tb -o wormhole_link_sim \
  && ./obj_dir/wormhole_link_sim +verilator+error+limit+100 \
  | tee /dev/stderr | grep -F '*** TEST PASSED ***' > /dev/null \
  && echo "wormhole link simulation passed" \
  || { echo "wormhole link simulation failed"; exit 1; }
